// ==== design/fm_param_store.sv ====
/*
 * Parameter store
 * Register array of any entry type, one registered read port
 * and one write port, cleared by reset
 */
`timescale 1ns/1ps
`default_nettype none

module fm_param_store #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 32
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [$clog2(depth)-1:0] rd_index,
    input  wire                     wr_en,
    input  wire [$clog2(depth)-1:0] wr_index,
    input  wire entry_t             wr_data,
    output entry_t                  rd_data
);

    entry_t mem [depth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_en) begin
                mem[wr_index] <= wr_data;
            end
            rd_data <= mem[rd_index];   // Ready one cycle later
        end
    end

endmodule

`default_nettype wire

// ==== design/fm_reg_decode.sv ====
/*
 * Register decode
 * Wishbone classic slave, turns register writes into slot-targeted
 * requests and acknowledges once the commit is reported
 */
`timescale 1ns/1ps
`default_nettype none

module fm_reg_decode (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   wb_cyc,
    input  wire                   wb_stb,
    input  wire                   wb_we,
    input  wire [7:0]             wb_adr,
    input  wire [7:0]             wb_dat_i,
    input  wire                   wr_done,
    input  wire [4:0]             cur_slot,
    output logic                  wb_ack,
    output logic [7:0]            wb_dat_o,
    output logic                  wr_valid,
    output fm_regs_pkg::wr_req_t  wr_req
);
    import fm_regs_pkg::*;

    wr_req_t dec_req;
    logic    accept;

    function automatic wr_req_t decode_addr(input logic [7:0] adr, input logic [7:0] dat);
        wr_req_t req;
        req.kind  = rk_none;
        req.index = adr[4:0];
        req.data  = dat;
        case (adr[7:5])
            3'd0: begin
                if (adr == 8'h08) begin
                    req.kind  = rk_key_on;
                    req.index = {2'b00, dat[2:0]};  // Channel comes from the data byte
                end
            end
            3'd1: begin
                req.index = {2'b00, adr[2:0]};
                case (adr[4:3])
                    2'd0:    req.kind = rk_ch_rl_fb_con;
                    2'd1:    req.kind = rk_ch_kc;
                    2'd2:    req.kind = rk_ch_kf;
                    default: req.kind = rk_ch_pms_ams;
                endcase
            end
            3'd2:    req.kind = rk_op_dt1_mul;
            3'd3:    req.kind = rk_op_tl;
            3'd4:    req.kind = rk_op_ks_ar;
            3'd5:    req.kind = rk_op_amsen_d1r;
            3'd6:    req.kind = rk_op_dt2_d2r;
            default: req.kind = rk_op_d1l_rr;
        endcase
        return req;
    endfunction

    assign dec_req = decode_addr(wb_adr, wb_dat_i);
    assign accept  = wb_cyc && wb_stb && !wr_valid && !wb_ack; // Idle and not in ack cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            if (wr_valid) begin
                if (wr_done) begin
                    wr_valid <= 1'b0;
                    wb_ack   <= 1'b1;
                end
            end else if (accept) begin
                if (wb_we && dec_req.kind != rk_none) begin
                    wr_valid <= 1'b1;
                end else begin
                    wb_ack <= 1'b1;             // Read or unmapped write
                end
            end
        end
    end

    // Request and read data only change on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_req <= dec_req;
            if (!wb_we) begin
                wb_dat_o <= {3'b000, cur_slot};
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fm_regs_pkg.sv ====
/*
 * FM synthesizer register subsystem package
 * Register kinds, operator and channel parameter records, write requests
 * and the per-slot result layout shared by all blocks
 */
`default_nettype none

package fm_regs_pkg;

    localparam int num_slots    = 32;
    localparam int num_channels = 8;

    // Write targets decoded from the register address
    typedef enum logic [3:0] {
        rk_none,
        rk_key_on,
        rk_ch_rl_fb_con,
        rk_ch_kc,
        rk_ch_kf,
        rk_ch_pms_ams,
        rk_op_dt1_mul,
        rk_op_tl,
        rk_op_ks_ar,
        rk_op_amsen_d1r,
        rk_op_dt2_d2r,
        rk_op_d1l_rr
    } reg_kind_t;

    typedef struct packed {
        reg_kind_t   kind;
        logic [4:0]  index;     // Slot, or channel in bits 2:0
        logic [7:0]  data;
    } wr_req_t;

    typedef struct packed {
        logic [2:0]  dt1;
        logic [3:0]  mul;
        logic [6:0]  tl;
        logic [1:0]  ks;
        logic [4:0]  ar;
        logic        amsen;
        logic [4:0]  d1r;
        logic [1:0]  dt2;
        logic [4:0]  d2r;
        logic [3:0]  d1l;
        logic [3:0]  rr;
    } op_params_t;

    typedef struct packed {
        logic [1:0]  rl;
        logic [2:0]  fb;
        logic [2:0]  con;       // Algorithm
        logic [6:0]  kc;
        logic [5:0]  kf;
        logic [2:0]  pms;
        logic [1:0]  ams;
    } ch_params_t;

    typedef struct packed {
        logic [3:0]  mod_src;   // C2, C1, M2, M1 from msb
        logic        carrier;
    } route_t;

    typedef struct packed {
        logic [4:0]  slot;
        logic        zero;
        logic        half;
        logic [3:0]  op_pos;    // One-hot of slot bits 4:3
        logic        key_on;
        op_params_t  op;
        ch_params_t  ch;
        route_t      route;
    } slot_out_t;

endpackage

`default_nettype wire

// ==== design/fm_regs_top.sv ====
/*
 * FM register subsystem top level
 * Wishbone register port, slot sequencer and per-slot result output
 */
`timescale 1ns/1ps
`default_nettype none

module fm_regs_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wb_cyc,
    input  wire                     wb_stb,
    input  wire                     wb_we,
    input  wire [7:0]               wb_adr,
    input  wire [7:0]               wb_dat_i,
    output wire                     wb_ack,
    output wire [7:0]               wb_dat_o,
    output wire fm_regs_pkg::slot_out_t slot_out
);
    import fm_regs_pkg::*;

    wr_req_t    wr_req;
    logic       wr_valid;
    logic       wr_done;
    logic [4:0] cur_slot;
    logic       slot_key_on;
    op_params_t slot_op;
    ch_params_t slot_ch;

    fm_reg_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wr_done  (wr_done),
        .cur_slot (cur_slot),
        .wb_ack   (wb_ack),
        .wb_dat_o (wb_dat_o),
        .wr_valid (wr_valid),
        .wr_req   (wr_req)
    );

    fm_slot_exec u_exec (
        .clk         (clk),
        .rst         (rst),
        .wr_valid    (wr_valid),
        .wr_req      (wr_req),
        .wr_done     (wr_done),
        .cur_slot    (cur_slot),
        .slot_key_on (slot_key_on),
        .slot_op     (slot_op),
        .slot_ch     (slot_ch)
    );

    fm_slot_result u_result (
        .clk         (clk),
        .rst         (rst),
        .cur_slot    (cur_slot),
        .slot_key_on (slot_key_on),
        .slot_op     (slot_op),
        .slot_ch     (slot_ch),
        .slot_out    (slot_out)
    );

endmodule

`default_nettype wire

// ==== design/fm_slot_exec.sv ====
/*
 * Slot sequencer and commit stage
 * Walks the 32 operator slots and merges pending register bytes
 * into the stores when the counter reaches the targeted slot or channel
 */
`timescale 1ns/1ps
`default_nettype none

module fm_slot_exec (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      wr_valid,
    input  wire fm_regs_pkg::wr_req_t wr_req,
    output logic                     wr_done,
    output logic [4:0]               cur_slot,
    output logic                     slot_key_on,
    output fm_regs_pkg::op_params_t  slot_op,
    output fm_regs_pkg::ch_params_t  slot_ch
);
    import fm_regs_pkg::*;

    logic [4:0]           next_slot;
    logic [num_slots-1:0] key_on_bits;    // Indexed by slot number
    logic                 is_op_kind;
    logic                 is_ch_kind;
    logic                 hit;
    logic                 op_wr_en;
    logic                 ch_wr_en;
    logic                 key_wr_en;
    op_params_t           op_merged;
    ch_params_t           ch_merged;

    assign next_slot = cur_slot + 5'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_slot <= 5'd0;
        end else begin
            cur_slot <= next_slot;          // Wraps at 31
        end
    end

    always_comb begin
        is_op_kind = wr_req.kind inside {rk_op_dt1_mul, rk_op_tl, rk_op_ks_ar,
                                         rk_op_amsen_d1r, rk_op_dt2_d2r, rk_op_d1l_rr};
        is_ch_kind = wr_req.kind inside {rk_ch_rl_fb_con, rk_ch_kc, rk_ch_kf,
                                         rk_ch_pms_ams};
        // Channel and key-on requests match on any operator of the channel
        if (is_op_kind) begin
            hit = cur_slot == wr_req.index;
        end else begin
            hit = cur_slot[2:0] == wr_req.index[2:0];
        end
        wr_done   = wr_valid && hit && wr_req.kind != rk_none;
        op_wr_en  = wr_done && is_op_kind;
        ch_wr_en  = wr_done && is_ch_kind;
        key_wr_en = wr_done && wr_req.kind == rk_key_on;
    end

    // Byte merge into the entry read for the current slot
    always_comb begin
        op_merged = slot_op;
        case (wr_req.kind)
            rk_op_dt1_mul: begin
                op_merged.dt1 = wr_req.data[6:4];
                op_merged.mul = wr_req.data[3:0];
            end
            rk_op_tl: op_merged.tl = wr_req.data[6:0];
            rk_op_ks_ar: begin
                op_merged.ks = wr_req.data[7:6];
                op_merged.ar = wr_req.data[4:0];
            end
            rk_op_amsen_d1r: begin
                op_merged.amsen = wr_req.data[7];
                op_merged.d1r   = wr_req.data[4:0];
            end
            rk_op_dt2_d2r: begin
                op_merged.dt2 = wr_req.data[7:6];
                op_merged.d2r = wr_req.data[4:0];
            end
            rk_op_d1l_rr: begin
                op_merged.d1l = wr_req.data[7:4];
                op_merged.rr  = wr_req.data[3:0];
            end
            default: ;
        endcase
    end

    always_comb begin
        ch_merged = slot_ch;
        case (wr_req.kind)
            rk_ch_rl_fb_con: begin
                ch_merged.rl  = wr_req.data[7:6];
                ch_merged.fb  = wr_req.data[5:3];
                ch_merged.con = wr_req.data[2:0];
            end
            rk_ch_kc: ch_merged.kc = wr_req.data[6:0];
            rk_ch_kf: ch_merged.kf = wr_req.data[7:2];
            rk_ch_pms_ams: begin
                ch_merged.pms = wr_req.data[6:4];
                ch_merged.ams = wr_req.data[1:0];
            end
            default: ;
        endcase
    end

    // Data bits 6:3 are C2, M2, C1, M1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_on_bits <= '0;
        end else if (key_wr_en) begin
            key_on_bits[{2'd0, cur_slot[2:0]}] <= wr_req.data[3];  // M1
            key_on_bits[{2'd1, cur_slot[2:0]}] <= wr_req.data[5];  // M2
            key_on_bits[{2'd2, cur_slot[2:0]}] <= wr_req.data[4];  // C1
            key_on_bits[{2'd3, cur_slot[2:0]}] <= wr_req.data[6];  // C2
        end
    end

    assign slot_key_on = key_on_bits[cur_slot];

    // Read ahead at the next slot, write back at the current one
    fm_param_store #(
        .entry_t (op_params_t),
        .depth   (num_slots)
    ) u_op_store (
        .clk      (clk),
        .rst      (rst),
        .rd_index (next_slot),
        .wr_en    (op_wr_en),
        .wr_index (cur_slot),
        .wr_data  (op_merged),
        .rd_data  (slot_op)
    );

    fm_param_store #(
        .entry_t (ch_params_t),
        .depth   (num_channels)
    ) u_ch_store (
        .clk      (clk),
        .rst      (rst),
        .rd_index (next_slot[2:0]),
        .wr_en    (ch_wr_en),
        .wr_index (cur_slot[2:0]),
        .wr_data  (ch_merged),
        .rd_data  (slot_ch)
    );

endmodule

`default_nettype wire

// ==== design/fm_slot_result.sv ====
/*
 * Slot result stage
 * Registers one slot's parameters with its position flags and
 * the modulation routing implied by the channel algorithm
 */
`timescale 1ns/1ps
`default_nettype none

module fm_slot_result (
    input  wire                       clk,
    input  wire                       rst,
    input  wire [4:0]                 cur_slot,
    input  wire                       slot_key_on,
    input  wire fm_regs_pkg::op_params_t slot_op,
    input  wire fm_regs_pkg::ch_params_t slot_ch,
    output fm_regs_pkg::slot_out_t    slot_out
);
    import fm_regs_pkg::*;

    logic [1:0] op_sel;     // 0 M1, 1 M2, 2 C1, 3 C2
    route_t     cur_route;

    // Per algorithm, modulator masks packed as {C2, C1, M2, M1}
    function automatic route_t alg_route(input logic [2:0] con, input logic [1:0] pos);
        logic [15:0] mods;
        logic [3:0]  cars;
        route_t      r;
        case (con)
            3'd0: begin
                mods = 16'b0010_0001_0100_0000;
                cars = 4'b1000;
            end
            3'd1: begin
                mods = 16'b0010_0000_0101_0000;
                cars = 4'b1000;
            end
            3'd2: begin
                mods = 16'b0011_0000_0100_0000;
                cars = 4'b1000;
            end
            3'd3: begin
                mods = 16'b0110_0001_0000_0000;
                cars = 4'b1000;
            end
            3'd4: begin
                mods = 16'b0010_0001_0000_0000;
                cars = 4'b1100;
            end
            3'd5: begin
                mods = 16'b0001_0001_0001_0000;  // M1 feeds all others
                cars = 4'b1110;
            end
            3'd6: begin
                mods = 16'b0000_0001_0000_0000;
                cars = 4'b1110;
            end
            default: begin
                mods = 16'b0;
                cars = 4'b1111;
            end
        endcase
        r.mod_src = mods[{pos, 2'b00} +: 4];
        r.carrier = cars[pos];
        return r;
    endfunction

    assign op_sel    = cur_slot[4:3];
    assign cur_route = alg_route(slot_ch.con, op_sel);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_out <= '0;
        end else begin
            slot_out.slot   <= cur_slot;
            slot_out.zero   <= cur_slot == 5'd0;
            slot_out.half   <= cur_slot[3:0] == 4'd0;  // Slots 0 and 16
            slot_out.op_pos <= 4'b0001 << op_sel;
            slot_out.key_on <= slot_key_on;
            slot_out.op     <= slot_op;
            slot_out.ch     <= slot_ch;
            slot_out.route  <= cur_route;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/fm_regs_pkg.sv
design/fm_param_store.sv
design/fm_reg_decode.sv
design/fm_slot_exec.sv
design/fm_slot_result.sv
design/fm_regs_top.sv
verification/fm_regs_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module fm_regs_tb -Mdir obj_dir -f filelist.f \
    && ./obj_dir/Vfm_regs_tb | tee /dev/stderr | grep "No errors" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verification/fm_regs_tb.sv ====
/*
 * Testbench for the FM register subsystem
 * Drives Wishbone register accesses and compares every slot output
 * against a register map model
 */
`timescale 1ns/1ps
`default_nettype none

module fm_regs_tb;
    import fm_regs_pkg::*;

    localparam int clk_period      = 10;
    localparam int num_op_writes   = 200;
    localparam int num_ch_writes   = 32;
    localparam int num_key_writes  = 16;
    localparam int num_con_writes  = 8;
    localparam int num_unmapped    = 4;
    localparam int num_reads       = 4;
    localparam int ack_limit       = 40;
    localparam int total_writes    = num_op_writes + num_ch_writes + num_key_writes
                                     + num_con_writes + num_unmapped;
    localparam int watchdog_cycles = total_writes * 80 + 2000;
    localparam logic [31:0] lfsr_seed = 32'd88438;
    localparam logic [7:0]  unmapped_adr [num_unmapped] = '{8'h00, 8'h10, 8'h07, 8'h1F};

    logic       clk;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [7:0] wb_adr;
    logic [7:0] wb_dat_i;
    logic       wb_ack;
    logic [7:0] wb_dat_o;
    slot_out_t  slot_out;

    op_params_t           model_op [num_slots];
    ch_params_t           model_ch [num_channels];
    logic [num_slots-1:0] model_key;
    logic [4:0]           model_cnt;    // Reference slot counter
    logic [4:0]           exp_slot;     // Slot due on slot_out
    logic [31:0]          lfsr_state;
    logic                 check_en;
    slot_out_t            exp_out;
    int                   error_count;
    int                   test_errors;
    int                   check_count;
    int                   tests_run;
    int                   failed_tests;

    fm_regs_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .wb_dat_o (wb_dat_o),
        .slot_out (slot_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests completed", watchdog_cycles);
        $display("Errors found");
        $finish;
    end

    // Output lags the counter by one cycle
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            model_cnt <= 5'd0;
            exp_slot  <= 5'd0;
        end else begin
            model_cnt <= model_cnt + 5'd1;
            exp_slot  <= model_cnt;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Sources per destination as {C2, C1, M2, M1} without M1 feedback
    function automatic route_t ref_route(input logic [2:0] con, input logic [1:0] pos);
        logic [3:0] src [4];
        logic [3:0] outs;
        route_t     r;
        src  = '{4'b0000, 4'b0000, 4'b0000, 4'b0000};
        outs = 4'b1000;                           // C2 only
        case (con)
            3'd0: begin
                src[2] = 4'b0001;
                src[1] = 4'b0100;
                src[3] = 4'b0010;
            end
            3'd1: begin
                src[1] = 4'b0101;
                src[3] = 4'b0010;
            end
            3'd2: begin
                src[1] = 4'b0100;
                src[3] = 4'b0011;
            end
            3'd3: begin
                src[2] = 4'b0001;
                src[3] = 4'b0110;
            end
            3'd4: begin
                src[2] = 4'b0001;
                src[3] = 4'b0010;
                outs   = 4'b1100;
            end
            3'd5: begin
                src[1] = 4'b0001;
                src[2] = 4'b0001;
                src[3] = 4'b0001;
                outs   = 4'b1110;
            end
            3'd6: begin
                src[2] = 4'b0001;
                outs   = 4'b1110;
            end
            default: outs = 4'b1111;
        endcase
        r.mod_src = src[pos];
        r.carrier = outs[pos];
        return r;
    endfunction

    function automatic slot_out_t expected_out(input logic [4:0] s);
        slot_out_t e;
        e.slot   = s;
        e.zero   = (s == 5'd0);
        e.half   = (s == 5'd0) || (s == 5'd16);
        case (s[4:3])
            2'd0:    e.op_pos = 4'b0001;  // M1
            2'd1:    e.op_pos = 4'b0010;  // M2
            2'd2:    e.op_pos = 4'b0100;  // C1
            default: e.op_pos = 4'b1000;  // C2
        endcase
        e.key_on = model_key[s];
        e.op     = model_op[s];
        e.ch     = model_ch[s[2:0]];
        e.route  = ref_route(model_ch[s[2:0]].con, s[4:3]);
        return e;
    endfunction

    task automatic model_write(input logic [7:0] adr, input logic [7:0] dat);
        logic [2:0] ch;
        logic [4:0] sl;
        ch = adr[2:0];
        sl = adr[4:0];
        if (adr == 8'h08) begin
            model_key[{2'd0, dat[2:0]}] = dat[3];   // M1
            model_key[{2'd2, dat[2:0]}] = dat[4];   // C1
            model_key[{2'd1, dat[2:0]}] = dat[5];   // M2
            model_key[{2'd3, dat[2:0]}] = dat[6];   // C2
        end else if (adr[7:3] == 5'h04) begin
            model_ch[ch].rl  = dat[7:6];
            model_ch[ch].fb  = dat[5:3];
            model_ch[ch].con = dat[2:0];
        end else if (adr[7:3] == 5'h05) begin
            model_ch[ch].kc = dat[6:0];
        end else if (adr[7:3] == 5'h06) begin
            model_ch[ch].kf = dat[7:2];
        end else if (adr[7:3] == 5'h07) begin
            model_ch[ch].pms = dat[6:4];
            model_ch[ch].ams = dat[1:0];
        end else if (adr[7:5] == 3'd2) begin
            model_op[sl].dt1 = dat[6:4];
            model_op[sl].mul = dat[3:0];
        end else if (adr[7:5] == 3'd3) begin
            model_op[sl].tl = dat[6:0];
        end else if (adr[7:5] == 3'd4) begin
            model_op[sl].ks = dat[7:6];
            model_op[sl].ar = dat[4:0];
        end else if (adr[7:5] == 3'd5) begin
            model_op[sl].amsen = dat[7];
            model_op[sl].d1r   = dat[4:0];
        end else if (adr[7:5] == 3'd6) begin
            model_op[sl].dt2 = dat[7:6];
            model_op[sl].d2r = dat[4:0];
        end else if (adr[7:5] == 3'd7) begin
            model_op[sl].d1l = dat[7:4];
            model_op[sl].rr  = dat[3:0];
        end
    endtask

    // One classic cycle held until ack
    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [7:0] dat,
                              output logic [7:0] rdata, output logic acked,
                              output logic [4:0] slot_at_start);
        int cycles;
        cycles = 0;
        acked  = 1'b0;
        @(posedge clk);
        #1;
        wb_cyc        = 1'b1;
        wb_stb        = 1'b1;
        wb_we         = we;
        wb_adr        = adr;
        wb_dat_i      = dat;
        slot_at_start = model_cnt;
        while (!acked && cycles < ack_limit) begin
            @(posedge clk);
            #1;
            cycles++;
            acked = wb_ack;
        end
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!acked) begin
            error_count++;
            test_errors++;
            $display("No ack within %0d cycles for the access to address %h", ack_limit, adr);
        end
    endtask

    // Skip one pass so the commit shows and compare the next full pass
    task automatic check_pass;
        repeat (num_slots + 1) @(posedge clk);
        #1;
        check_en = 1'b1;
        repeat (num_slots) @(posedge clk);
        #1;
        check_en = 1'b0;
    endtask

    task automatic write_and_check(input logic [7:0] adr, input logic [7:0] dat);
        logic [7:0] rdata;
        logic       acked;
        logic [4:0] slot_at_start;
        bus_access(1'b1, adr, dat, rdata, acked, slot_at_start);
        if (acked) begin
            model_write(adr, dat);
        end
        check_pass();
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d %s: passed", num, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed with %0d mismatches", num, name, test_errors);
        end
        test_errors = 0;
    endtask

    always @(negedge clk) begin
        if (check_en) begin
            exp_out = expected_out(exp_slot);
            check_count++;
            if (slot_out.slot !== exp_slot) begin
                error_count++;
                test_errors++;
                $display("Error: slot_out.slot got %h expected %h", slot_out.slot, exp_slot);
            end
            if (slot_out !== exp_out) begin
                error_count++;
                test_errors++;
                $display("Error: slot_out at slot %h got %h expected %h",
                         exp_slot, slot_out, exp_out);
            end
        end
    end

    initial begin
        logic [7:0] adr;
        logic [7:0] dat;
        logic [7:0] rdata;
        logic       acked;
        logic [4:0] slot_at_start;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = 8'h00;
        wb_dat_i     = 8'h00;
        check_en     = 1'b0;
        lfsr_state   = lfsr_seed;
        error_count  = 0;
        test_errors  = 0;
        check_count  = 0;
        tests_run    = 0;
        failed_tests = 0;
        model_key    = '0;
        for (int i = 0; i < num_slots; i++) begin
            model_op[i] = '0;
        end
        for (int i = 0; i < num_channels; i++) begin
            model_ch[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        @(posedge clk);     // First registered slot after reset
        #1;
        check_en = 1'b1;
        repeat (2 * num_slots) @(posedge clk);
        #1;
        check_en = 1'b0;
        end_test(1, "reset state and slot sequence");

        for (int i = 0; i < num_op_writes; i++) begin
            do begin
                adr = 8'(rand_bits(8));
            end while (adr < 8'h40);
            dat = 8'(rand_bits(8));
            write_and_check(adr, dat);
        end
        end_test(2, "operator register writes");

        for (int i = 0; i < num_ch_writes; i++) begin
            adr = {3'b001, 5'(rand_bits(5))};
            dat = 8'(rand_bits(8));
            write_and_check(adr, dat);
        end
        end_test(3, "channel register writes");

        for (int i = 0; i < num_key_writes; i++) begin
            dat = 8'(rand_bits(8));
            write_and_check(8'h08, dat);
        end
        end_test(4, "key-on writes");

        for (int c = 0; c < num_con_writes; c++) begin
            adr = {5'b00100, 3'(rand_bits(3))};
            dat = {5'(rand_bits(5)), 3'(c)};
            write_and_check(adr, dat);
        end
        end_test(5, "algorithm routing");

        for (int i = 0; i < num_reads; i++) begin
            adr = 8'(rand_bits(8));
            bus_access(1'b0, adr, 8'h00, rdata, acked, slot_at_start);
            if (acked && rdata !== {3'b000, slot_at_start}) begin
                error_count++;
                test_errors++;
                $display("Error: wb_dat_o got %h expected %h", rdata, {3'b000, slot_at_start});
            end
        end
        for (int i = 0; i < num_unmapped; i++) begin
            dat = 8'(rand_bits(8));
            write_and_check(unmapped_adr[i], dat);
        end
        end_test(6, "reads and unmapped writes");

        $display("Tests run %0d, failed %0d, slot checks %0d, errors %0d",
                 tests_run, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
